//--- source/rob_cfg_pkg.sv
package rob_cfg_pkg;

    ////////////////////////////////////////
    // Buffer geometry

    // One slot per outstanding instruction
    localparam int ROB_ENTRIES = 8;

    // Instruction id doubles as the slot index
    localparam int ROB_ID_W    = 3;

    ////////////////////////////////////////
    // Payload field widths

    // Register file data
    localparam int DATA_W      = 32;

    // Register file address
    localparam int REG_ADDR_W  = 5;

    // Program counter
    localparam int PC_W        = 32;

    // Faulting address carried by an exception
    localparam int XCPT_ADDR_W = 32;

endpackage

//--- source/rob_types_pkg.sv
package rob_types_pkg;

    import rob_cfg_pkg::*;

    ////////////////////////////////////////
    // Exceptions

    typedef enum logic [1:0]
    {
        XCPT_ILLEGAL_INSTR,
        XCPT_ITLB_MISS,
        XCPT_DTLB_MISS,
        XCPT_MISALIGNED
    } xcpt_type_e;

    typedef struct packed
    {
        logic                   valid;
        xcpt_type_e             xcpt_type;
        logic [PC_W-1:0]        pc;
        logic [XCPT_ADDR_W-1:0] addr;
    } xcpt_info_t;

    ////////////////////////////////////////
    // Writeback and stored entry

    typedef struct packed
    {
        logic                   valid;
        logic [ROB_ID_W-1:0]    instr_id;
        logic                   rf_wen;
        logic [REG_ADDR_W-1:0]  rf_dest;
        logic [DATA_W-1:0]      rf_data;
        xcpt_info_t             xcpt;
    } wb_req_t;

    typedef struct packed
    {
        logic                   rf_wen;
        logic [REG_ADDR_W-1:0]  rf_dest;
        logic [DATA_W-1:0]      rf_data;
        xcpt_info_t             xcpt;
    } rob_entry_t;

    ////////////////////////////////////////
    // Retirement

    // Where this cycle's retiring instruction comes from
    typedef enum logic [2:0]
    {
        RETIRE_NONE,
        RETIRE_STORED,
        RETIRE_ALU,
        RETIRE_MUL,
        RETIRE_CACHE
    } retire_src_e;

    typedef struct packed
    {
        retire_src_e            src;
        logic [ROB_ID_W-1:0]    instr_id;
        rob_entry_t             entry;
    } retire_t;

    typedef struct packed
    {
        logic                   wen;
        logic [REG_ADDR_W-1:0]  dest;
        logic [DATA_W-1:0]      data;
        logic [ROB_ID_W-1:0]    instr_id;
    } rf_write_t;

    ////////////////////////////////////////
    // Operand bypass

    typedef struct packed
    {
        logic [ROB_ID_W-1:0]    src1_id;
        logic [ROB_ID_W-1:0]    src2_id;
    } bypass_query_t;

    typedef struct packed
    {
        logic                   hit1;
        logic                   hit2;
        logic [DATA_W-1:0]      data1;
        logic [DATA_W-1:0]      data2;
    } bypass_result_t;

    // Entry contents of a writeback, without its strobe and id
    function automatic rob_entry_t wb_to_entry(input wb_req_t wb);
        return '{rf_wen: wb.rf_wen, rf_dest: wb.rf_dest, rf_data: wb.rf_data, xcpt: wb.xcpt};
    endfunction

endpackage

//--- source/rob_entry_store.sv
module rob_entry_store
(
    input  logic                                    clock,
    input  logic                                    rst_n,

    // Writebacks from the execution ports
    input  rob_types_pkg::wb_req_t                  alu_wb,
    input  rob_types_pkg::wb_req_t                  mul_wb,
    input  rob_types_pkg::wb_req_t                  cache_wb,

    // Instruction leaving the buffer this cycle
    input  rob_types_pkg::retire_t                  retire,
    input  logic                                    invalidate_buffer,

    // Stored state
    output logic [rob_cfg_pkg::ROB_ENTRIES-1:0]     entry_valid,
    output rob_types_pkg::rob_entry_t [rob_cfg_pkg::ROB_ENTRIES-1:0] entries,
    output logic [rob_cfg_pkg::ROB_ID_W-1:0]        tail,
    output logic                                    rob_full
);

    import rob_cfg_pkg::*;
    import rob_types_pkg::*;

    wb_req_t    [2:0]               wb_ports;
    logic       [2:0]               port_retiring;

    logic       [ROB_ENTRIES-1:0]   valid_q;
    logic       [ROB_ENTRIES-1:0]   valid_next;
    rob_entry_t [ROB_ENTRIES-1:0]   entries_q;
    rob_entry_t [ROB_ENTRIES-1:0]   entries_next;
    logic       [ROB_ID_W-1:0]      tail_q;
    logic       [ROB_ID_W-1:0]      tail_next;

    // Port order matches the retire priority
    assign wb_ports      = {cache_wb, mul_wb, alu_wb};
    assign port_retiring = {retire.src == RETIRE_CACHE,
                            retire.src == RETIRE_MUL,
                            retire.src == RETIRE_ALU};

    ////////////////////////////////////////
    // Next state

    always_comb
    begin
        valid_next   = valid_q;
        entries_next = entries_q;
        tail_next    = tail_q;

        // Pop the oldest slot
        if (retire.src != RETIRE_NONE)
        begin
            if (retire.src == RETIRE_STORED)
                valid_next[tail_q] = 1'b0;

            if (tail_q == ROB_ID_W'(ROB_ENTRIES - 1))
                tail_next = '0;
            else
                tail_next = tail_q + 1'b1;
        end

        // A port that retires straight through leaves its slot empty
        for (int p = 0; p < 3; p++)
        begin
            if (wb_ports[p].valid && !rob_full)
            begin
                valid_next[wb_ports[p].instr_id]   = !port_retiring[p];
                entries_next[wb_ports[p].instr_id] = wb_to_entry(wb_ports[p]);
            end
        end
    end

    ////////////////////////////////////////
    // Registers

    always_ff @(posedge clock)
    begin
        if (!rst_n || invalidate_buffer)
        begin
            valid_q <= '0;
            tail_q  <= '0;
        end
        else
        begin
            valid_q <= valid_next;
            tail_q  <= tail_next;
        end
    end

    always_ff @(posedge clock)
    begin
        entries_q <= entries_next;
    end

    assign entry_valid = valid_q;
    assign entries     = entries_q;
    assign tail        = tail_q;
    assign rob_full    = &valid_q;

    // Upstream hands out each id once per round
    for (genvar g = 0; g < 3; g++)
    begin : g_wb_check
        a_no_overwrite: assert property (@(posedge clock) disable iff (!rst_n)
            (wb_ports[g].valid && !rob_full) |-> !valid_q[wb_ports[g].instr_id])
            else $error("writeback on port %0d hits a valid slot", g);
    end

endmodule

//--- source/rob_retire_select.sv
module rob_retire_select
(
    // Writebacks from the execution ports
    input  rob_types_pkg::wb_req_t                  alu_wb,
    input  rob_types_pkg::wb_req_t                  mul_wb,
    input  rob_types_pkg::wb_req_t                  cache_wb,

    // Stored state
    input  logic [rob_cfg_pkg::ROB_ENTRIES-1:0]     entry_valid,
    input  rob_types_pkg::rob_entry_t [rob_cfg_pkg::ROB_ENTRIES-1:0] entries,
    input  logic [rob_cfg_pkg::ROB_ID_W-1:0]        tail,

    output rob_types_pkg::retire_t                  retire
);

    import rob_cfg_pkg::*;
    import rob_types_pkg::*;

    logic   alu_at_tail;
    logic   mul_at_tail;
    logic   cache_at_tail;

    assign alu_at_tail   = alu_wb.valid   && (alu_wb.instr_id   == tail);
    assign mul_at_tail   = mul_wb.valid   && (mul_wb.instr_id   == tail);
    assign cache_at_tail = cache_wb.valid && (cache_wb.instr_id == tail);

    ////////////////////////////////////////
    // Oldest instruction

    always_comb
    begin
        retire          = '0;
        retire.src      = RETIRE_NONE;
        retire.instr_id = tail;

        // Stored tail first, then a port finishing the tail this cycle
        if (entry_valid[tail])
        begin
            retire.src   = RETIRE_STORED;
            retire.entry = entries[tail];
        end
        else if (alu_at_tail)
        begin
            retire.src   = RETIRE_ALU;
            retire.entry = wb_to_entry(alu_wb);
        end
        else if (mul_at_tail)
        begin
            retire.src   = RETIRE_MUL;
            retire.entry = wb_to_entry(mul_wb);
        end
        else if (cache_at_tail)
        begin
            retire.src   = RETIRE_CACHE;
            retire.entry = wb_to_entry(cache_wb);
        end
    end

    ////////////////////////////////////////
    // Port id uniqueness

    // Each id is in flight on a single port
    always_comb
    begin
        if (alu_wb.valid && mul_wb.valid)
            a_alu_mul: assert final (alu_wb.instr_id != mul_wb.instr_id)
                else $error("ALU and MUL write back id %0d together", alu_wb.instr_id);
        if (alu_wb.valid && cache_wb.valid)
            a_alu_cache: assert final (alu_wb.instr_id != cache_wb.instr_id)
                else $error("ALU and cache write back id %0d together", alu_wb.instr_id);
        if (mul_wb.valid && cache_wb.valid)
            a_mul_cache: assert final (mul_wb.instr_id != cache_wb.instr_id)
                else $error("MUL and cache write back id %0d together", mul_wb.instr_id);
    end

endmodule

//--- source/rob_commit_output.sv
module rob_commit_output
(
    input  logic                        clock,
    input  logic                        rst_n,

    // Instruction leaving the buffer this cycle
    input  rob_types_pkg::retire_t      retire,

    // Writebacks, watched for exceptions
    input  rob_types_pkg::wb_req_t      alu_wb,
    input  rob_types_pkg::wb_req_t      mul_wb,
    input  rob_types_pkg::wb_req_t      cache_wb,

    output rob_types_pkg::rf_write_t    rf_write,
    output rob_types_pkg::xcpt_info_t   xcpt_report,
    output logic                        flush_pipeline,
    output logic                        flush_cache
);

    import rob_cfg_pkg::*;
    import rob_types_pkg::*;

    logic                       retiring;
    logic                       retire_xcpt;
    logic                       wb_xcpt;

    logic                       rf_wen_q;
    logic [REG_ADDR_W-1:0]      rf_dest_q;
    logic [DATA_W-1:0]          rf_data_q;
    logic [ROB_ID_W-1:0]        rf_id_q;

    logic                       xcpt_valid_q;
    xcpt_type_e                 xcpt_type_q;
    logic [PC_W-1:0]            xcpt_pc_q;
    logic [XCPT_ADDR_W-1:0]     xcpt_addr_q;

    logic                       flush_pipeline_q;
    logic                       flush_pipeline_next;

    assign retiring    = retire.src != RETIRE_NONE;
    assign retire_xcpt = retiring && retire.entry.xcpt.valid;
    assign wb_xcpt     = (alu_wb.valid   && alu_wb.xcpt.valid)
                      || (mul_wb.valid   && mul_wb.xcpt.valid)
                      || (cache_wb.valid && cache_wb.xcpt.valid);

    ////////////////////////////////////////
    // Flush level

    // A new faulting writeback outranks the retiring one
    always_comb
    begin
        flush_pipeline_next = flush_pipeline_q;
        if (retire_xcpt)
            flush_pipeline_next = 1'b0;
        if (wb_xcpt)
            flush_pipeline_next = 1'b1;
    end

    ////////////////////////////////////////
    // Output registers

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            rf_wen_q         <= 1'b0;
            xcpt_valid_q     <= 1'b0;
            flush_pipeline_q <= 1'b0;
        end
        else
        begin
            rf_wen_q         <= retiring && retire.entry.rf_wen && !retire.entry.xcpt.valid;
            xcpt_valid_q     <= retire_xcpt;
            flush_pipeline_q <= flush_pipeline_next;
        end
    end

    always_ff @(posedge clock)
    begin
        if (retiring)
        begin
            rf_dest_q   <= retire.entry.rf_dest;
            rf_data_q   <= retire.entry.rf_data;
            rf_id_q     <= retire.instr_id;
            xcpt_type_q <= retire.entry.xcpt.xcpt_type;
            xcpt_pc_q   <= retire.entry.xcpt.pc;
            xcpt_addr_q <= retire.entry.xcpt.addr;
        end
    end

    assign rf_write = '{wen: rf_wen_q, dest: rf_dest_q, data: rf_data_q, instr_id: rf_id_q};

    assign xcpt_report = '{valid: xcpt_valid_q, xcpt_type: xcpt_type_q,
                           pc: xcpt_pc_q, addr: xcpt_addr_q};

    assign flush_pipeline = flush_pipeline_q;

    // Cache flush only once the faulting instruction has left the buffer
    assign flush_cache = xcpt_valid_q;

endmodule

//--- source/rob_bypass.sv
module rob_bypass
(
    // Source ids of one consumer
    input  rob_types_pkg::bypass_query_t            query,

    // Stored state
    input  logic [rob_cfg_pkg::ROB_ENTRIES-1:0]     entry_valid,
    input  rob_types_pkg::rob_entry_t [rob_cfg_pkg::ROB_ENTRIES-1:0] entries,

    // Writebacks arriving this cycle
    input  rob_types_pkg::wb_req_t                  alu_wb,
    input  rob_types_pkg::wb_req_t                  mul_wb,
    input  rob_types_pkg::wb_req_t                  cache_wb,

    output rob_types_pkg::bypass_result_t           result
);

    import rob_cfg_pkg::*;
    import rob_types_pkg::*;

    // Hit flag on top of the data
    logic [DATA_W:0]    src1_found;
    logic [DATA_W:0]    src2_found;

    ////////////////////////////////////////
    // Lookup of one source

    function automatic logic [DATA_W:0] lookup(input logic [ROB_ID_W-1:0] id);
        logic [DATA_W:0] found;

        found = '0;
        // Stored results first, then this cycle's ports in retire priority
        if (entry_valid[id] && entries[id].rf_wen)
            found = {1'b1, entries[id].rf_data};
        else if (alu_wb.valid && alu_wb.rf_wen && (alu_wb.instr_id == id))
            found = {1'b1, alu_wb.rf_data};
        else if (mul_wb.valid && mul_wb.rf_wen && (mul_wb.instr_id == id))
            found = {1'b1, mul_wb.rf_data};
        else if (cache_wb.valid && cache_wb.rf_wen && (cache_wb.instr_id == id))
            found = {1'b1, cache_wb.rf_data};
        return found;
    endfunction

    always_comb
    begin
        src1_found = lookup(query.src1_id);
        src2_found = lookup(query.src2_id);
    end

    assign result = '{hit1:  src1_found[DATA_W],
                      hit2:  src2_found[DATA_W],
                      data1: src1_found[DATA_W-1:0],
                      data2: src2_found[DATA_W-1:0]};

endmodule

//--- source/reorder_buffer.sv
module reorder_buffer
(
    input  logic                            clock,
    input  logic                            rst_n,

    // Writebacks from the execution ports
    input  rob_types_pkg::wb_req_t          alu_wb,
    input  rob_types_pkg::wb_req_t          mul_wb,
    input  rob_types_pkg::wb_req_t          cache_wb,

    // Drop everything in flight
    input  logic                            invalidate_buffer,

    // Commit
    output rob_types_pkg::rf_write_t        rf_write,
    output rob_types_pkg::xcpt_info_t       xcpt_report,
    output logic                            flush_pipeline,
    output logic                            flush_cache,
    output logic                            rob_full,

    // Operand bypass
    input  rob_types_pkg::bypass_query_t    alu_query,
    input  rob_types_pkg::bypass_query_t    mul_query,
    output rob_types_pkg::bypass_result_t   alu_bypass,
    output rob_types_pkg::bypass_result_t   mul_bypass
);

    import rob_cfg_pkg::*;
    import rob_types_pkg::*;

    logic       [ROB_ENTRIES-1:0]   entry_valid;
    rob_entry_t [ROB_ENTRIES-1:0]   entries;
    logic       [ROB_ID_W-1:0]      tail;
    retire_t                        retire;

    ////////////////////////////////////////
    // Storage and retirement

    rob_entry_store entry_store_i
    (
        .clock              ( clock             ),
        .rst_n              ( rst_n             ),
        .alu_wb             ( alu_wb            ),
        .mul_wb             ( mul_wb            ),
        .cache_wb           ( cache_wb          ),
        .retire             ( retire            ),
        .invalidate_buffer  ( invalidate_buffer ),
        .entry_valid        ( entry_valid       ),
        .entries            ( entries           ),
        .tail               ( tail              ),
        .rob_full           ( rob_full          )
    );

    rob_retire_select retire_select_i
    (
        .alu_wb             ( alu_wb            ),
        .mul_wb             ( mul_wb            ),
        .cache_wb           ( cache_wb          ),
        .entry_valid        ( entry_valid       ),
        .entries            ( entries           ),
        .tail               ( tail              ),
        .retire             ( retire            )
    );

    rob_commit_output commit_output_i
    (
        .clock              ( clock             ),
        .rst_n              ( rst_n             ),
        .retire             ( retire            ),
        .alu_wb             ( alu_wb            ),
        .mul_wb             ( mul_wb            ),
        .cache_wb           ( cache_wb          ),
        .rf_write           ( rf_write          ),
        .xcpt_report        ( xcpt_report       ),
        .flush_pipeline     ( flush_pipeline    ),
        .flush_cache        ( flush_cache       )
    );

    ////////////////////////////////////////
    // One bypass unit per consumer

    rob_bypass alu_bypass_i
    (
        .query              ( alu_query         ),
        .entry_valid        ( entry_valid       ),
        .entries            ( entries           ),
        .alu_wb             ( alu_wb            ),
        .mul_wb             ( mul_wb            ),
        .cache_wb           ( cache_wb          ),
        .result             ( alu_bypass        )
    );

    rob_bypass mul_bypass_i
    (
        .query              ( mul_query         ),
        .entry_valid        ( entry_valid       ),
        .entries            ( entries           ),
        .alu_wb             ( alu_wb            ),
        .mul_wb             ( mul_wb            ),
        .cache_wb           ( cache_wb          ),
        .result             ( mul_bypass        )
    );

endmodule

//--- verif/tb_reorder_buffer.sv
module tb_reorder_buffer;

    timeunit 1ns;
    timeprecision 1ps;

    import rob_cfg_pkg::*;
    import rob_types_pkg::*;

    localparam int CLK_PERIOD_NS   = 40;
    localparam int RESET_CYCLES    = 16;
    localparam int WATCHDOG_CYCLES = 4000;

    logic           clock;
    logic           rst_n;
    wb_req_t        alu_wb;
    wb_req_t        mul_wb;
    wb_req_t        cache_wb;
    logic           invalidate_buffer;
    bypass_query_t  alu_query;
    bypass_query_t  mul_query;
    rf_write_t      rf_write;
    xcpt_info_t     xcpt_report;
    logic           flush_pipeline;
    logic           flush_cache;
    logic           rob_full;
    bypass_result_t alu_bypass;
    bypass_result_t mul_bypass;

    // Reference model state, all updated with non-blocking assignments
    wb_req_t [2:0]              wb_ports;
    logic [ROB_ENTRIES-1:0]     model_pend;
    wb_req_t [ROB_ENTRIES-1:0]  model_recs;
    logic [ROB_ID_W-1:0]        model_tail;
    int                         model_retired;
    logic                       model_commit;
    logic [ROB_ID_W-1:0]        model_commit_id;
    wb_req_t                    model_commit_rec;
    logic                       model_flush;
    logic                       exp_wen;
    logic                       exp_xcpt;
    bypass_result_t             exp_alu_bp;
    bypass_result_t             exp_mul_bp;

    // Highest sequence number sent per id in the current stream
    int                         last_sent [ROB_ENTRIES];

    reorder_buffer dut_i
    (
        .clock              ( clock             ),
        .rst_n              ( rst_n             ),
        .alu_wb             ( alu_wb            ),
        .mul_wb             ( mul_wb            ),
        .cache_wb           ( cache_wb          ),
        .invalidate_buffer  ( invalidate_buffer ),
        .rf_write           ( rf_write          ),
        .xcpt_report        ( xcpt_report       ),
        .flush_pipeline     ( flush_pipeline    ),
        .flush_cache        ( flush_cache       ),
        .rob_full           ( rob_full          ),
        .alu_query          ( alu_query         ),
        .mul_query          ( mul_query         ),
        .alu_bypass         ( alu_bypass        ),
        .mul_bypass         ( mul_bypass        )
    );

    initial
    begin
        clock = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clock = ~clock;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test, input logic [127:0] expected,
                                   input logic [127:0] actual);
        abort_run($sformatf("[ERROR] %s: expected %0h, actual %0h", test, expected, actual));
    endtask

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        abort_run("Timeout: the commit stream did not finish in time");
    end

    ////////////////////////////////////////
    // Reference model

    assign wb_ports = {cache_wb, mul_wb, alu_wb};

    always @(posedge clock)
    begin : model_step
        logic [ROB_ENTRIES-1:0]     pend_next;
        wb_req_t [ROB_ENTRIES-1:0]  recs_next;
        wb_req_t                    retiring;
        logic                       retired;
        logic                       xcpt_seen;

        pend_next = model_pend;
        recs_next = model_recs;
        retiring  = model_recs[model_tail];
        retired   = model_pend[model_tail];
        xcpt_seen = 1'b0;
        pend_next[model_tail] = 1'b0;
        for (int p = 0; p < 3; p++)
        begin
            if (wb_ports[p].valid)
            begin
                recs_next[wb_ports[p].instr_id] = wb_ports[p];
                xcpt_seen = xcpt_seen | wb_ports[p].xcpt.valid;
                // Oldest id arriving with an empty slot leaves at once
                if (!model_pend[model_tail] && wb_ports[p].instr_id == model_tail)
                begin
                    retired  = 1'b1;
                    retiring = wb_ports[p];
                end
                else
                    pend_next[wb_ports[p].instr_id] = 1'b1;
            end
        end

        if (!rst_n)
        begin
            model_pend    <= '0;
            model_tail    <= '0;
            model_retired <= 0;
            model_commit  <= 1'b0;
            model_flush   <= 1'b0;
        end
        else
        begin
            model_commit     <= retired;
            model_commit_id  <= model_tail;
            model_commit_rec <= retiring;
            model_recs       <= recs_next;
            if (xcpt_seen)
                model_flush <= 1'b1;
            else if (retired && retiring.xcpt.valid)
                model_flush <= 1'b0;
            if (invalidate_buffer)
            begin
                model_pend    <= '0;
                model_tail    <= '0;
                model_retired <= 0;
            end
            else
            begin
                model_pend    <= pend_next;
                model_tail    <= model_tail + ROB_ID_W'(retired);
                model_retired <= model_retired + int'(retired);
            end
        end
    end

    // A source hits while its result is written with rf_wen and not yet committed
    function automatic bypass_result_t expected_bypass(input bypass_query_t q,
            input logic [ROB_ENTRIES-1:0] pend, input wb_req_t [ROB_ENTRIES-1:0] recs,
            input wb_req_t [2:0] ports);
        bypass_result_t r;

        r = '0;
        for (int p = 0; p < 3; p++)
        begin
            if (ports[p].valid && ports[p].rf_wen && ports[p].instr_id == q.src1_id)
                r = '{hit1: 1'b1, hit2: r.hit2, data1: ports[p].rf_data, data2: r.data2};
            if (ports[p].valid && ports[p].rf_wen && ports[p].instr_id == q.src2_id)
                r = '{hit1: r.hit1, hit2: 1'b1, data1: r.data1, data2: ports[p].rf_data};
        end
        if (pend[q.src1_id] && recs[q.src1_id].rf_wen)
            r = '{hit1: 1'b1, hit2: r.hit2, data1: recs[q.src1_id].rf_data, data2: r.data2};
        if (pend[q.src2_id] && recs[q.src2_id].rf_wen)
            r = '{hit1: r.hit1, hit2: 1'b1, data1: r.data1, data2: recs[q.src2_id].rf_data};
        return r;
    endfunction

    assign exp_wen    = model_commit && model_commit_rec.rf_wen && !model_commit_rec.xcpt.valid;
    assign exp_xcpt   = model_commit && model_commit_rec.xcpt.valid;
    assign exp_alu_bp = expected_bypass(alu_query, model_pend, model_recs, wb_ports);
    assign exp_mul_bp = expected_bypass(mul_query, model_pend, model_recs, wb_ports);

    ////////////////////////////////////////
    // Checks

    a_reset_state: assert property (@(posedge clock) $rose(rst_n) |->
        !(rf_write.wen || xcpt_report.valid || flush_pipeline || flush_cache || rob_full))
        else report_mismatch("reset_state", 0, $sampled({rf_write.wen, xcpt_report.valid,
                             flush_pipeline, flush_cache, rob_full}));

    a_rf_wen: assert property (@(posedge clock) disable iff (!rst_n) rf_write.wen == exp_wen)
        else report_mismatch("rf_wen", $sampled(exp_wen), $sampled(rf_write.wen));

    a_commit_fields: assert property (@(posedge clock) disable iff (!rst_n) model_commit |->
        {rf_write.instr_id, rf_write.dest, rf_write.data}
            == {model_commit_id, model_commit_rec.rf_dest, model_commit_rec.rf_data})
        else report_mismatch("commit_fields",
            $sampled({model_commit_id, model_commit_rec.rf_dest, model_commit_rec.rf_data}),
            $sampled({rf_write.instr_id, rf_write.dest, rf_write.data}));

    a_xcpt_valid: assert property (@(posedge clock) disable iff (!rst_n)
        xcpt_report.valid == exp_xcpt)
        else report_mismatch("xcpt_valid", $sampled(exp_xcpt), $sampled(xcpt_report.valid));

    a_xcpt_fields: assert property (@(posedge clock) disable iff (!rst_n)
        exp_xcpt |-> xcpt_report == model_commit_rec.xcpt)
        else report_mismatch("xcpt_fields", $sampled(model_commit_rec.xcpt),
                             $sampled(xcpt_report));

    a_flush_cache: assert property (@(posedge clock) disable iff (!rst_n)
        flush_cache == exp_xcpt)
        else report_mismatch("flush_cache", $sampled(exp_xcpt), $sampled(flush_cache));

    a_flush_pipeline: assert property (@(posedge clock) disable iff (!rst_n)
        flush_pipeline == model_flush)
        else report_mismatch("flush_pipeline", $sampled(model_flush), $sampled(flush_pipeline));

    a_rob_full: assert property (@(posedge clock) disable iff (!rst_n)
        rob_full == &model_pend)
        else report_mismatch("rob_full", $sampled(&model_pend), $sampled(rob_full));

    a_alu_bypass: assert property (@(posedge clock) disable iff (!rst_n)
        alu_bypass == exp_alu_bp)
        else report_mismatch("alu_bypass", $sampled(exp_alu_bp), $sampled(alu_bypass));

    a_mul_bypass: assert property (@(posedge clock) disable iff (!rst_n)
        mul_bypass == exp_mul_bp)
        else report_mismatch("mul_bypass", $sampled(exp_mul_bp), $sampled(mul_bypass));

    ////////////////////////////////////////
    // Stimulus

    function automatic wb_req_t random_wb(input int seq);
        wb_req_t wb;

        wb                = '0;
        wb.valid          = 1'b1;
        wb.instr_id       = ROB_ID_W'(seq % ROB_ENTRIES);
        wb.rf_wen         = 1'($urandom_range(1));
        wb.rf_dest        = REG_ADDR_W'($urandom);
        wb.rf_data        = $urandom;
        wb.xcpt.valid     = ($urandom_range(9) == 0);
        wb.xcpt.xcpt_type = xcpt_type_e'(2'($urandom_range(3)));
        wb.xcpt.pc        = $urandom;
        wb.xcpt.addr      = $urandom;
        return wb;
    endfunction

    // Window of ids handed out is the 8 oldest unretired sequence numbers
    task automatic send_cycle(input int seq_limit, input int pct);
        wb_req_t [2:0]  drive;
        int             cand[$];
        int             base;
        int             pick;

        drive = '0;
        @(posedge clock);
        base = model_retired;
        for (int s = base; s < base + ROB_ENTRIES; s++)
        begin
            if (s < seq_limit && last_sent[s % ROB_ENTRIES] < s)
                cand.push_back(s);
        end
        for (int p = 0; p < 3; p++)
        begin
            if (cand.size() > 0 && $urandom_range(99) < pct)
            begin
                pick     = $urandom_range(cand.size() - 1);
                drive[p] = random_wb(cand[pick]);
                last_sent[cand[pick] % ROB_ENTRIES] = cand[pick];
                cand.delete(pick);
            end
        end
        alu_wb    <= drive[0];
        mul_wb    <= drive[1];
        cache_wb  <= drive[2];
        alu_query <= '{src1_id: ROB_ID_W'($urandom), src2_id: ROB_ID_W'($urandom)};
        mul_query <= '{src1_id: ROB_ID_W'($urandom), src2_id: ROB_ID_W'($urandom)};
    endtask

    task automatic restart_ids();
        foreach (last_sent[i])
            last_sent[i] = -1;
    endtask

    task automatic run_stream(input int seq_limit, input int pct);
        restart_ids();
        while (model_retired < seq_limit)
            send_cycle(seq_limit, pct);
    endtask

    // One quiet cycle with invalidate, then one idle cycle for the model to restart
    task automatic drop_in_flight();
        @(posedge clock);
        alu_wb            <= '0;
        mul_wb            <= '0;
        cache_wb          <= '0;
        invalidate_buffer <= 1'b1;
        @(posedge clock);
        invalidate_buffer <= 1'b0;
    endtask

    initial
    begin
        void'($urandom(32'hf36f));
        rst_n             = 1'b0;
        alu_wb            = '0;
        mul_wb            = '0;
        cache_wb          = '0;
        invalidate_buffer = 1'b0;
        alu_query         = '0;
        mul_query         = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;

        run_stream(1000, 70);
        for (int r = 0; r < 6; r++)
        begin
            restart_ids();
            repeat (25) send_cycle(1000, 60);
            drop_in_flight();
        end
        run_stream(300, 30);

        repeat (2) send_cycle(0, 0);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- tb.f
source/rob_cfg_pkg.sv
source/rob_types_pkg.sv
source/rob_entry_store.sv
source/rob_retire_select.sv
source/rob_commit_output.sv
source/rob_bypass.sv
source/reorder_buffer.sv
verif/tb_reorder_buffer.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_reorder_buffer -f tb.f -o tb_reorder_buffer

sim_output=$(./obj_dir/tb_reorder_buffer 2>&1 || true)
echo "$sim_output"

if grep -q "^RESULT: PASS$" <<< "$sim_output"; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed"
exit 1
